//--- src/lce_cfg_pkg.sv
// Local coherence engine configuration
// Cache geometry for a direct-mapped private cache, the credit limit
// for misses in flight, the memory-stall timeout, and the vector types
// for addresses, address fields, data blocks and counters
package lce_cfg_pkg;

  // Physical address and cache geometry
  localparam int ADDR_WIDTH   = 32;
  localparam int BLOCK_WIDTH  = 64;
  localparam int SETS         = 64;
  localparam int OFFSET_WIDTH = $clog2(BLOCK_WIDTH / 8);
  localparam int INDEX_WIDTH  = $clog2(SETS);
  localparam int TAG_WIDTH    = ADDR_WIDTH - INDEX_WIDTH - OFFSET_WIDTH;

  // Engine id as seen by the directory
  localparam int LCE_ID_WIDTH = 4;

  // Misses in flight
  localparam int CREDITS      = 2;
  localparam int CREDIT_WIDTH = $clog2(CREDITS + 1);

  // Stalled memory cycles before busy is forced
  localparam int TIMEOUT_LIMIT = 4;
  localparam int TIMEOUT_WIDTH = $clog2(TIMEOUT_LIMIT + 1);

  // Address and its fields
  typedef logic [ADDR_WIDTH-1:0]   paddr_t;
  typedef logic [TAG_WIDTH-1:0]    tag_t;
  typedef logic [INDEX_WIDTH-1:0]  index_t;

  // One cache block
  typedef logic [BLOCK_WIDTH-1:0]  block_t;

  typedef logic [LCE_ID_WIDTH-1:0] lce_id_t;

  // Counter types sized to hold their upper limit
  typedef logic [CREDIT_WIDTH-1:0]  credit_cnt_t;
  typedef logic [TIMEOUT_WIDTH-1:0] timeout_cnt_t;

endpackage

//--- src/lce_msg_pkg.sv
// Local coherence engine message encodings
// Opcodes of the request, command and response messages exchanged
// with the directory, the coherence states written to the tag memory,
// and the state encodings of both engine FSMs
package lce_msg_pkg;

  // Cache miss type, carried into the request message
  typedef enum logic [0:0] {
    e_req_rd_miss = 1'b0,
    e_req_st_miss = 1'b1
  } req_type_e;

  // Directory command opcodes
  typedef enum logic [1:0] {
    e_cmd_sync = 2'b00,
    e_cmd_fill = 2'b01,
    e_cmd_inv  = 2'b10
  } cmd_op_e;

  // Response opcodes back to the directory
  typedef enum logic [1:0] {
    e_resp_sync_ack = 2'b00,
    e_resp_coh_ack  = 2'b01,
    e_resp_inv_ack  = 2'b10
  } resp_type_e;

  // Block coherence state as kept in the tag memory
  typedef enum logic [1:0] {
    e_coh_i = 2'b00,
    e_coh_s = 2'b01,
    e_coh_e = 2'b10
  } coh_state_e;

  // Request engine
  typedef enum logic [0:0] {
    e_req_idle = 1'b0,
    e_req_send = 1'b1
  } req_state_e;

  // Command engine
  typedef enum logic [1:0] {
    e_cmd_idle       = 2'b00,
    e_cmd_tag_write  = 2'b01,
    e_cmd_data_write = 2'b10,
    e_cmd_respond    = 2'b11
  } cmd_state_e;

endpackage

//--- src/lce_status_if.sv
// Engine status bundle
// Carries readiness, credit and memory-stall status from the request
// and command engines to the busy controller, and the combined busy
// back to the request engine
interface lce_status_if;

  logic req_ready;
  logic credits_full;
  logic credits_empty;
  logic cmd_ready;
  logic mem_stall;
  logic busy;

  modport req (
    output req_ready,
    output credits_full,
    output credits_empty,
    input  busy
  );

  modport cmd (
    output cmd_ready,
    output mem_stall
  );

  modport ctrl (
    input  req_ready,
    input  credits_full,
    input  cmd_ready,
    input  mem_stall,
    output busy
  );

endinterface

//--- src/lce_req_engine.sv
// LCE request engine
// Accepts cache misses while the engine is not busy and turns each one
// into a coherence request message for the directory. Keeps count of
// the misses in flight; a credit is taken when the message is accepted
// and returned when the matching fill completes
module lce_req_engine (
  input  logic                  clk_i,
  input  logic                  arst_n_i,

  input  lce_cfg_pkg::lce_id_t  lce_id_i,

  // Cache miss, valid/yumi
  input  logic                  cache_req_v_i,
  input  lce_msg_pkg::req_type_e cache_req_type_i,
  input  lce_cfg_pkg::paddr_t   cache_req_addr_i,
  output logic                  cache_req_yumi_o,

  // Credit return from the command engine
  input  logic                  fill_done_i,

  lce_status_if.req             status,

  // Request message, valid/ready
  output logic                  lce_req_v_o,
  input  logic                  lce_req_ready_i,
  output lce_msg_pkg::req_type_e lce_req_type_o,
  output lce_cfg_pkg::paddr_t   lce_req_addr_o,
  output lce_cfg_pkg::lce_id_t  lce_req_src_o
);

  import lce_cfg_pkg::*;
  import lce_msg_pkg::*;

  req_state_e  state_r;
  req_state_e  state_n;
  credit_cnt_t credit_cnt_r;
  logic        req_sent;
  logic        credit_ret;

  // Busy already covers a pending message, so no state check here
  assign cache_req_yumi_o = cache_req_v_i & ~status.busy;

  assign req_sent   = lce_req_v_o & lce_req_ready_i;
  assign credit_ret = fill_done_i & (credit_cnt_r != '0);

  always_comb begin
    state_n = state_r;
    case (state_r)
      e_req_idle: begin
        if (cache_req_yumi_o) begin
          state_n = e_req_send;
        end
      end
      e_req_send: begin
        if (req_sent) begin
          state_n = e_req_idle;
        end
      end
      default: state_n = e_req_idle;
    endcase
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_r <= e_req_idle;
    end else begin
      state_r <= state_n;
    end
  end

  // Message payload, block aligned
  always_ff @(posedge clk_i) begin
    if (cache_req_yumi_o) begin
      lce_req_type_o <= cache_req_type_i;
      lce_req_addr_o <= {cache_req_addr_i[ADDR_WIDTH-1:OFFSET_WIDTH], {OFFSET_WIDTH{1'b0}}};
      lce_req_src_o  <= lce_id_i;
    end
  end

  assign lce_req_v_o = (state_r == e_req_send);

  // Up/down credit counter
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      credit_cnt_r <= '0;
    end else if (req_sent && !credit_ret) begin
      credit_cnt_r <= credit_cnt_r + 1'b1;
    end else if (credit_ret && !req_sent) begin
      credit_cnt_r <= credit_cnt_r - 1'b1;
    end
  end

  assign status.req_ready     = (state_r == e_req_idle);
  assign status.credits_full  = (credit_cnt_r == credit_cnt_t'(CREDITS));
  assign status.credits_empty = (credit_cnt_r == '0);

endmodule

//--- src/lce_cmd_engine.sv
// LCE command engine
// Runs sync, fill and invalidate commands from the directory. A fill
// writes the tag memory and then the data memory, an invalidate writes
// the tag memory only, and every command ends with a response message.
// The engine reports ready to the cache only once a sync has finished
module lce_cmd_engine (
  input  logic                      clk_i,
  input  logic                      arst_n_i,

  input  lce_cfg_pkg::lce_id_t      lce_id_i,

  // Directory command, valid/yumi
  input  logic                      lce_cmd_v_i,
  input  lce_msg_pkg::cmd_op_e      lce_cmd_op_i,
  input  lce_cfg_pkg::paddr_t       lce_cmd_addr_i,
  input  lce_msg_pkg::coh_state_e   lce_cmd_state_i,
  input  lce_cfg_pkg::block_t       lce_cmd_data_i,
  output logic                      lce_cmd_yumi_o,

  // Tag memory packet, valid/yumi
  output logic                      tag_mem_pkt_v_o,
  output lce_cfg_pkg::index_t       tag_mem_pkt_index_o,
  output lce_cfg_pkg::tag_t         tag_mem_pkt_tag_o,
  output lce_msg_pkg::coh_state_e   tag_mem_pkt_state_o,
  input  logic                      tag_mem_pkt_yumi_i,

  // Data memory packet, valid/yumi
  output logic                      data_mem_pkt_v_o,
  output lce_cfg_pkg::index_t       data_mem_pkt_index_o,
  output lce_cfg_pkg::block_t       data_mem_pkt_data_o,
  input  logic                      data_mem_pkt_yumi_i,

  // Response message, valid/ready
  output logic                      lce_resp_v_o,
  input  logic                      lce_resp_ready_i,
  output lce_msg_pkg::resp_type_e   lce_resp_type_o,
  output lce_cfg_pkg::paddr_t       lce_resp_addr_o,
  output lce_cfg_pkg::lce_id_t      lce_resp_src_o,

  output logic                      cache_req_complete_o,
  output logic                      fill_done_o,

  lce_status_if.cmd                 status
);

  import lce_cfg_pkg::*;
  import lce_msg_pkg::*;

  cmd_state_e state_r;
  cmd_state_e state_n;
  cmd_op_e    op_r;
  index_t     index_r;
  tag_t       tag_r;
  coh_state_e coh_r;
  block_t     data_r;
  logic       sync_done_r;
  logic       resp_done;

  assign lce_cmd_yumi_o = lce_cmd_v_i & (state_r == e_cmd_idle);
  assign resp_done      = lce_resp_v_o & lce_resp_ready_i;

  always_comb begin
    state_n = state_r;
    case (state_r)
      e_cmd_idle: begin
        if (lce_cmd_yumi_o) begin
          // Sync touches no memory
          if (lce_cmd_op_i == e_cmd_sync) begin
            state_n = e_cmd_respond;
          end else begin
            state_n = e_cmd_tag_write;
          end
        end
      end
      e_cmd_tag_write: begin
        if (tag_mem_pkt_yumi_i) begin
          state_n = (op_r == e_cmd_fill) ? e_cmd_data_write : e_cmd_respond;
        end
      end
      e_cmd_data_write: begin
        if (data_mem_pkt_yumi_i) begin
          state_n = e_cmd_respond;
        end
      end
      e_cmd_respond: begin
        if (resp_done) begin
          state_n = e_cmd_idle;
        end
      end
      default: state_n = e_cmd_idle;
    endcase
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_r     <= e_cmd_idle;
      sync_done_r <= 1'b0;
    end else begin
      state_r <= state_n;
      if (resp_done && op_r == e_cmd_sync) begin
        sync_done_r <= 1'b1;
      end
    end
  end

  // Command fields held for the whole command
  always_ff @(posedge clk_i) begin
    if (lce_cmd_yumi_o) begin
      op_r    <= lce_cmd_op_i;
      index_r <= lce_cmd_addr_i[OFFSET_WIDTH +: INDEX_WIDTH];
      tag_r   <= lce_cmd_addr_i[ADDR_WIDTH-1 -: TAG_WIDTH];
      coh_r   <= (lce_cmd_op_i == e_cmd_inv) ? e_coh_i : lce_cmd_state_i;
      data_r  <= lce_cmd_data_i;
    end
  end

  assign tag_mem_pkt_v_o     = (state_r == e_cmd_tag_write);
  assign tag_mem_pkt_index_o = index_r;
  assign tag_mem_pkt_tag_o   = tag_r;
  assign tag_mem_pkt_state_o = coh_r;

  assign data_mem_pkt_v_o     = (state_r == e_cmd_data_write);
  assign data_mem_pkt_index_o = index_r;
  assign data_mem_pkt_data_o  = data_r;

  always_comb begin
    case (op_r)
      e_cmd_fill: lce_resp_type_o = e_resp_coh_ack;
      e_cmd_inv:  lce_resp_type_o = e_resp_inv_ack;
      default:    lce_resp_type_o = e_resp_sync_ack;
    endcase
  end

  assign lce_resp_v_o    = (state_r == e_cmd_respond);
  assign lce_resp_addr_o = {tag_r, index_r, {OFFSET_WIDTH{1'b0}}};
  assign lce_resp_src_o  = lce_id_i;

  // Fill ends when its coh_ack leaves, which also frees one credit
  assign cache_req_complete_o = resp_done & (op_r == e_cmd_fill);
  assign fill_done_o          = cache_req_complete_o;

  assign status.cmd_ready = sync_done_r;
  assign status.mem_stall = (tag_mem_pkt_v_o & ~tag_mem_pkt_yumi_i)
                          | (data_mem_pkt_v_o & ~data_mem_pkt_yumi_i);

endmodule

//--- src/lce_busy_ctrl.sv
// LCE busy controller
// The engine shares the tag and data memory ports with the cache and
// can only use them in cycles the cache leaves free. When a packet has
// waited too long, busy is forced so the cache stops issuing and a
// memory cycle opens up. Busy also covers full credits, a missing
// sync and a pending request message
module lce_busy_ctrl (
  input  logic        clk_i,
  input  logic        arst_n_i,

  lce_status_if.ctrl  status
);

  import lce_cfg_pkg::*;

  timeout_cnt_t timeout_cnt_r;
  logic         timeout;

  // Counts stalled cycles, cleared as soon as the stall ends
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      timeout_cnt_r <= '0;
    end else if (!status.mem_stall) begin
      timeout_cnt_r <= '0;
    end else if (!timeout) begin
      timeout_cnt_r <= timeout_cnt_r + 1'b1;
    end
  end

  // Saturates at the limit
  assign timeout = (timeout_cnt_r == timeout_cnt_t'(TIMEOUT_LIMIT));

  assign status.busy = status.credits_full
                     | timeout
                     | ~status.cmd_ready
                     | ~status.req_ready;

endmodule

//--- src/lce_top.sv
// Local coherence engine top level
// Sits between a direct-mapped private cache and the directory. The
// request engine turns cache misses into request messages, the command
// engine runs directory commands against the tag and data memories,
// and the busy controller tells the cache when to hold off
module lce_top (
  input  logic                      clk_i,
  input  logic                      arst_n_i,

  input  lce_cfg_pkg::lce_id_t      lce_id_i,

  // Cache side
  input  logic                      cache_req_v_i,
  input  lce_msg_pkg::req_type_e    cache_req_type_i,
  input  lce_cfg_pkg::paddr_t       cache_req_addr_i,
  output logic                      cache_req_yumi_o,
  output logic                      cache_req_busy_o,
  output logic                      cache_req_credits_full_o,
  output logic                      cache_req_credits_empty_o,
  output logic                      cache_req_complete_o,

  // Tag and data memory packets
  output logic                      tag_mem_pkt_v_o,
  output lce_cfg_pkg::index_t       tag_mem_pkt_index_o,
  output lce_cfg_pkg::tag_t         tag_mem_pkt_tag_o,
  output lce_msg_pkg::coh_state_e   tag_mem_pkt_state_o,
  input  logic                      tag_mem_pkt_yumi_i,
  output logic                      data_mem_pkt_v_o,
  output lce_cfg_pkg::index_t       data_mem_pkt_index_o,
  output lce_cfg_pkg::block_t       data_mem_pkt_data_o,
  input  logic                      data_mem_pkt_yumi_i,

  // Directory side
  output logic                      lce_req_v_o,
  input  logic                      lce_req_ready_i,
  output lce_msg_pkg::req_type_e    lce_req_type_o,
  output lce_cfg_pkg::paddr_t       lce_req_addr_o,
  output lce_cfg_pkg::lce_id_t      lce_req_src_o,
  input  logic                      lce_cmd_v_i,
  input  lce_msg_pkg::cmd_op_e      lce_cmd_op_i,
  input  lce_cfg_pkg::paddr_t       lce_cmd_addr_i,
  input  lce_msg_pkg::coh_state_e   lce_cmd_state_i,
  input  lce_cfg_pkg::block_t       lce_cmd_data_i,
  output logic                      lce_cmd_yumi_o,
  output logic                      lce_resp_v_o,
  input  logic                      lce_resp_ready_i,
  output lce_msg_pkg::resp_type_e   lce_resp_type_o,
  output lce_cfg_pkg::paddr_t       lce_resp_addr_o,
  output lce_cfg_pkg::lce_id_t      lce_resp_src_o
);

  lce_status_if status ();

  // Credit return path
  logic fill_done;

  lce_req_engine u_req (
    .clk_i            (clk_i),
    .arst_n_i         (arst_n_i),
    .lce_id_i         (lce_id_i),
    .cache_req_v_i    (cache_req_v_i),
    .cache_req_type_i (cache_req_type_i),
    .cache_req_addr_i (cache_req_addr_i),
    .cache_req_yumi_o (cache_req_yumi_o),
    .fill_done_i      (fill_done),
    .status           (status),
    .lce_req_v_o      (lce_req_v_o),
    .lce_req_ready_i  (lce_req_ready_i),
    .lce_req_type_o   (lce_req_type_o),
    .lce_req_addr_o   (lce_req_addr_o),
    .lce_req_src_o    (lce_req_src_o)
  );

  lce_cmd_engine u_cmd (
    .clk_i                (clk_i),
    .arst_n_i             (arst_n_i),
    .lce_id_i             (lce_id_i),
    .lce_cmd_v_i          (lce_cmd_v_i),
    .lce_cmd_op_i         (lce_cmd_op_i),
    .lce_cmd_addr_i       (lce_cmd_addr_i),
    .lce_cmd_state_i      (lce_cmd_state_i),
    .lce_cmd_data_i       (lce_cmd_data_i),
    .lce_cmd_yumi_o       (lce_cmd_yumi_o),
    .tag_mem_pkt_v_o      (tag_mem_pkt_v_o),
    .tag_mem_pkt_index_o  (tag_mem_pkt_index_o),
    .tag_mem_pkt_tag_o    (tag_mem_pkt_tag_o),
    .tag_mem_pkt_state_o  (tag_mem_pkt_state_o),
    .tag_mem_pkt_yumi_i   (tag_mem_pkt_yumi_i),
    .data_mem_pkt_v_o     (data_mem_pkt_v_o),
    .data_mem_pkt_index_o (data_mem_pkt_index_o),
    .data_mem_pkt_data_o  (data_mem_pkt_data_o),
    .data_mem_pkt_yumi_i  (data_mem_pkt_yumi_i),
    .lce_resp_v_o         (lce_resp_v_o),
    .lce_resp_ready_i     (lce_resp_ready_i),
    .lce_resp_type_o      (lce_resp_type_o),
    .lce_resp_addr_o      (lce_resp_addr_o),
    .lce_resp_src_o       (lce_resp_src_o),
    .cache_req_complete_o (cache_req_complete_o),
    .fill_done_o          (fill_done),
    .status               (status)
  );

  lce_busy_ctrl u_busy (
    .clk_i    (clk_i),
    .arst_n_i (arst_n_i),
    .status   (status)
  );

  assign cache_req_busy_o          = status.busy;
  assign cache_req_credits_full_o  = status.credits_full;
  assign cache_req_credits_empty_o = status.credits_empty;

endmodule

//--- testbench/tb_lce.sv
// Testbench for the local coherence engine
// Models the directory with random ready stalls and the tag and data
// memories with a holdable yumi, drives misses and commands, and checks
// messages, packets and busy with assertions
module tb_lce;

  import lce_cfg_pkg::*;
  import lce_msg_pkg::*;

  localparam int WAIT_LIMIT = 100;
  localparam lce_id_t MY_ID = 4'h5;

  logic clk_i, arst_n_i;
  lce_id_t lce_id_i;
  logic cache_req_v_i, cache_req_yumi_o, cache_req_busy_o;
  req_type_e cache_req_type_i;
  paddr_t cache_req_addr_i;
  logic cache_req_credits_full_o, cache_req_credits_empty_o, cache_req_complete_o;
  logic tag_mem_pkt_v_o, tag_mem_pkt_yumi_i;
  index_t tag_mem_pkt_index_o;
  tag_t tag_mem_pkt_tag_o;
  coh_state_e tag_mem_pkt_state_o;
  logic data_mem_pkt_v_o, data_mem_pkt_yumi_i;
  index_t data_mem_pkt_index_o;
  block_t data_mem_pkt_data_o;
  logic lce_req_v_o, lce_req_ready_i;
  req_type_e lce_req_type_o;
  paddr_t lce_req_addr_o;
  lce_id_t lce_req_src_o;
  logic lce_cmd_v_i, lce_cmd_yumi_o;
  cmd_op_e lce_cmd_op_i;
  paddr_t lce_cmd_addr_i;
  coh_state_e lce_cmd_state_i;
  block_t lce_cmd_data_i;
  logic lce_resp_v_o, lce_resp_ready_i;
  resp_type_e lce_resp_type_o;
  paddr_t lce_resp_addr_o;
  lce_id_t lce_resp_src_o;

  int errors = 0;
  int timeouts = 0;
  int complete_cnt = 0;
  int miss_cnt = 0;
  int req_cnt = 0;
  int fill_cnt = 0;
  logic [31:0] rng = 32'h7f12;
  logic hold_tag = 1'b0;

  // Captured transfers
  logic [36:0] req_q[$];
  logic [30:0] tag_q[$];
  logic [69:0] data_q[$];
  logic [37:0] resp_q[$];

  lce_top DUT (.*);

  initial begin
    clk_i = 1'b0;
    forever #10 clk_i = ~clk_i;
  end

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // Directory model with ready about three cycles in four
  always @(negedge clk_i) begin
    rng = xorshift(rng);
    lce_req_ready_i = rng[0] | rng[1];
    lce_resp_ready_i = rng[2] | rng[3];
  end

  // Memory model
  always @(negedge clk_i) begin
    tag_mem_pkt_yumi_i = tag_mem_pkt_v_o & ~hold_tag;
    data_mem_pkt_yumi_i = data_mem_pkt_v_o;
  end

  always @(posedge clk_i) begin
    if (lce_req_v_o && lce_req_ready_i) begin
      req_q.push_back({lce_req_type_o, lce_req_src_o, lce_req_addr_o});
      req_cnt++;
    end
    if (tag_mem_pkt_v_o && tag_mem_pkt_yumi_i)
      tag_q.push_back({tag_mem_pkt_state_o, tag_mem_pkt_tag_o, tag_mem_pkt_index_o});
    if (data_mem_pkt_v_o && data_mem_pkt_yumi_i)
      data_q.push_back({data_mem_pkt_index_o, data_mem_pkt_data_o});
    if (lce_resp_v_o && lce_resp_ready_i)
      resp_q.push_back({lce_resp_type_o, lce_resp_src_o, lce_resp_addr_o});
    if (cache_req_complete_o)
      complete_cnt++;
  end

  a_yumi_not_busy: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    cache_req_yumi_o |-> !cache_req_busy_o)
    else begin
      errors++;
      $display("Fail cache_req_busy_o: got %h expected %h", cache_req_busy_o, 1'b0);
    end

  a_req_hold: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    lce_req_v_o && !lce_req_ready_i |=> lce_req_v_o && $stable(lce_req_addr_o)
      && $stable(lce_req_type_o) && $stable(lce_req_src_o))
    else begin
      errors++;
      $display("Request message changed while the directory was not ready");
    end

  a_tag_hold: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    tag_mem_pkt_v_o && !tag_mem_pkt_yumi_i |=> tag_mem_pkt_v_o
      && $stable(tag_mem_pkt_index_o) && $stable(tag_mem_pkt_tag_o)
      && $stable(tag_mem_pkt_state_o))
    else begin
      errors++;
      $display("Tag packet changed before the memory took it");
    end

  a_resp_hold: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    lce_resp_v_o && !lce_resp_ready_i |=> lce_resp_v_o && $stable(lce_resp_type_o)
      && $stable(lce_resp_addr_o) && $stable(lce_resp_src_o))
    else begin
      errors++;
      $display("Response message changed while the directory was not ready");
    end

  a_complete: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    cache_req_complete_o |-> lce_resp_v_o && lce_resp_ready_i
      && lce_resp_type_o == e_resp_coh_ack)
    else begin
      errors++;
      $display("Completion pulsed outside a coh_ack transfer");
    end

  task automatic check_eq(input string name, input logic [63:0] got, input logic [63:0] exp);
    assert (got === exp) else begin
      errors++;
      $display("Fail %s: got %h expected %h", name, got, exp);
    end
  endtask

  task automatic report_timeout(input string what);
    timeouts++;
    $display("Timed out waiting for %s", what);
  endtask

  task automatic wait_busy(input logic level);
    int n;
    n = 0;
    while (cache_req_busy_o !== level && n < WAIT_LIMIT) begin
      @(negedge clk_i);
      n++;
    end
    if (n == WAIT_LIMIT) report_timeout("busy to change");
  endtask

  task automatic issue_miss(input req_type_e t, input paddr_t a);
    logic [36:0] m;
    int n;
    @(negedge clk_i);
    cache_req_v_i = 1'b1;
    cache_req_type_i = t;
    cache_req_addr_i = a;
    n = 0;
    do begin
      @(posedge clk_i);
      n++;
    end while (!cache_req_yumi_o && n < WAIT_LIMIT);
    if (n == WAIT_LIMIT) report_timeout("cache request yumi");
    @(negedge clk_i);
    cache_req_v_i = 1'b0;
    miss_cnt++;
    n = 0;
    while (req_q.size() == 0 && n < WAIT_LIMIT) begin
      @(posedge clk_i);
      n++;
    end
    if (req_q.size() == 0) begin
      report_timeout("request message");
    end else begin
      m = req_q.pop_front();
      check_eq("lce_req_type_o", 64'(m[36]), 64'(t));
      check_eq("lce_req_src_o", 64'(m[35:32]), 64'(MY_ID));
      check_eq("lce_req_addr_o", 64'(m[31:0]), 64'(a & 32'hffff_fff8));
    end
  endtask

  task automatic run_cmd(input cmd_op_e op, input paddr_t a, input coh_state_e st,
                         input coh_state_e exp_st, input block_t d,
                         input resp_type_e exp_resp);
    logic [30:0] t;
    logic [69:0] dp;
    logic [37:0] r;
    int n;
    @(negedge clk_i);
    lce_cmd_v_i = 1'b1;
    lce_cmd_op_i = op;
    lce_cmd_addr_i = a;
    lce_cmd_state_i = st;
    lce_cmd_data_i = d;
    n = 0;
    do begin
      @(posedge clk_i);
      n++;
    end while (!lce_cmd_yumi_o && n < WAIT_LIMIT);
    if (n == WAIT_LIMIT) report_timeout("command yumi");
    @(negedge clk_i);
    lce_cmd_v_i = 1'b0;
    n = 0;
    while (resp_q.size() == 0 && n < WAIT_LIMIT) begin
      @(posedge clk_i);
      n++;
    end
    if (op != e_cmd_sync) begin
      if (tag_q.size() == 0) begin
        report_timeout("tag packet");
      end else begin
        t = tag_q.pop_front();
        check_eq("tag_mem_pkt_index_o", 64'(t[5:0]), 64'(a[8:3]));
        check_eq("tag_mem_pkt_tag_o", 64'(t[28:6]), 64'(a[31:9]));
        check_eq("tag_mem_pkt_state_o", 64'(t[30:29]), 64'(exp_st));
      end
    end
    if (op == e_cmd_fill) begin
      if (data_q.size() == 0) begin
        report_timeout("data packet");
      end else begin
        dp = data_q.pop_front();
        check_eq("data_mem_pkt_index_o", 64'(dp[69:64]), 64'(a[8:3]));
        check_eq("data_mem_pkt_data_o", dp[63:0], d);
      end
    end
    if (resp_q.size() == 0) begin
      report_timeout("response message");
    end else begin
      r = resp_q.pop_front();
      check_eq("lce_resp_type_o", 64'(r[37:36]), 64'(exp_resp));
      check_eq("lce_resp_src_o", 64'(r[35:32]), 64'(MY_ID));
      if (op != e_cmd_sync)
        check_eq("lce_resp_addr_o", 64'(r[31:0]), 64'(a & 32'hffff_fff8));
    end
  endtask

  initial begin
    repeat (5000) @(posedge clk_i);
    $display("Run exceeded its cycle limit");
    $display("Simulation failed");
    $finish;
  end

  initial begin
    arst_n_i = 1'b0;
    lce_id_i = MY_ID;
    cache_req_v_i = 1'b0;
    cache_req_type_i = e_req_rd_miss;
    cache_req_addr_i = '0;
    tag_mem_pkt_yumi_i = 1'b0;
    data_mem_pkt_yumi_i = 1'b0;
    lce_req_ready_i = 1'b0;
    lce_resp_ready_i = 1'b0;
    lce_cmd_v_i = 1'b0;
    lce_cmd_op_i = e_cmd_sync;
    lce_cmd_addr_i = '0;
    lce_cmd_state_i = e_coh_i;
    lce_cmd_data_i = '0;
    repeat (3) @(negedge clk_i);
    arst_n_i = 1'b1;

    @(negedge clk_i);
    check_eq("lce_req_v_o", 64'(lce_req_v_o), 64'(0));
    check_eq("lce_resp_v_o", 64'(lce_resp_v_o), 64'(0));
    check_eq("tag_mem_pkt_v_o", 64'(tag_mem_pkt_v_o), 64'(0));
    check_eq("data_mem_pkt_v_o", 64'(data_mem_pkt_v_o), 64'(0));
    check_eq("cache_req_yumi_o", 64'(cache_req_yumi_o), 64'(0));
    check_eq("lce_cmd_yumi_o", 64'(lce_cmd_yumi_o), 64'(0));
    check_eq("cache_req_complete_o", 64'(cache_req_complete_o), 64'(0));
    check_eq("cache_req_busy_o", 64'(cache_req_busy_o), 64'(1));
    check_eq("cache_req_credits_empty_o", 64'(cache_req_credits_empty_o), 64'(1));

    run_cmd(e_cmd_sync, '0, e_coh_i, e_coh_i, '0, e_resp_sync_ack);
    wait_busy(1'b0);

    // Fill both credits
    issue_miss(e_req_rd_miss, 32'h1234_5677);
    issue_miss(e_req_st_miss, 32'habcd_0105);
    @(negedge clk_i);
    check_eq("cache_req_credits_full_o", 64'(cache_req_credits_full_o), 64'(1));
    check_eq("cache_req_busy_o", 64'(cache_req_busy_o), 64'(1));

    // A miss offered while busy must not be taken
    cache_req_v_i = 1'b1;
    cache_req_addr_i = 32'h0000_0040;
    repeat (3) @(negedge clk_i);
    cache_req_v_i = 1'b0;

    run_cmd(e_cmd_fill, 32'h1234_5677, e_coh_e, e_coh_e, 64'hdead_beef_0123_4567,
            e_resp_coh_ack);
    fill_cnt++;
    @(negedge clk_i);
    check_eq("cache_req_credits_full_o", 64'(cache_req_credits_full_o), 64'(0));
    run_cmd(e_cmd_fill, 32'habcd_0105, e_coh_s, e_coh_s, 64'h0f1e_2d3c_4b5a_6978,
            e_resp_coh_ack);
    fill_cnt++;
    @(negedge clk_i);
    check_eq("cache_req_credits_empty_o", 64'(cache_req_credits_empty_o), 64'(1));

    run_cmd(e_cmd_inv, 32'h0000_0fc8, e_coh_e, e_coh_i, '0, e_resp_inv_ack);
    wait_busy(1'b0);

    // Memory port stall long enough to force busy
    @(posedge clk_i);
    hold_tag = 1'b1;
    @(negedge clk_i);
    lce_cmd_v_i = 1'b1;
    lce_cmd_op_i = e_cmd_inv;
    lce_cmd_addr_i = 32'h8765_4320;
    @(negedge clk_i);
    lce_cmd_v_i = 1'b0;
    wait_busy(1'b1);
    check_eq("tag_mem_pkt_v_o", 64'(tag_mem_pkt_v_o), 64'(1));
    repeat (2) @(negedge clk_i);
    check_eq("cache_req_busy_o", 64'(cache_req_busy_o), 64'(1));
    @(posedge clk_i);
    hold_tag = 1'b0;
    wait_busy(1'b0);
    check_eq("tag_mem_pkt_v_o", 64'(tag_mem_pkt_v_o), 64'(0));

    repeat (5) @(negedge clk_i);
    check_eq("cache_req_complete_o count", 64'(complete_cnt), 64'(fill_cnt));
    check_eq("request message count", 64'(req_cnt), 64'(miss_cnt));

    $display("Checks failed: %0d, timeouts: %0d", errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

//--- lce.f
src/lce_cfg_pkg.sv
src/lce_msg_pkg.sv
src/lce_status_if.sv
src/lce_req_engine.sv
src/lce_cmd_engine.sv
src/lce_busy_ctrl.sv
src/lce_top.sv
testbench/tb_lce.sv

//--- Makefile
TOP := tb_lce

.PHONY: all lint clean

all: obj_dir/V$(TOP)
	@out=$$(./obj_dir/V$(TOP)); echo "$$out"; \
	echo "$$out" | grep -q "Simulation completed successfully"

obj_dir/V$(TOP): lce.f $(wildcard src/*.sv testbench/*.sv)
	verilator --binary --timing --assert -f lce.f --top-module $(TOP)

lint:
	verilator --lint-only --timing --assert -f lce.f --top-module $(TOP)

clean:
	rm -rf obj_dir
